/* design/cfg_net_pkg.sv */
`default_nettype none

package cfg_net_pkg;

  // field widths
  localparam int DATA_MAX_BITS = 32;  // widest payload a packet can carry
  localparam int FRAME_LEN     = 8;   // payload bits between inserted zeros
  localparam int ID_W          = 8;   // node id
  localparam int LEN_W         = 8;   // packet length field
  localparam int TAG_W         = 8;   // sequence tag
  localparam int VALID_W       = 2;   // "0 then 1" start pair
  localparam int FRAME_BIT_W   = 1;   // each framing zero

  // framed payload field, closing frame bit included
  localparam int RX_LEN = DATA_MAX_BITS + DATA_MAX_BITS / FRAME_LEN + FRAME_BIT_W;

  // valid pair, three frame bits, length and id
  localparam int HDR_LEN = VALID_W + 3 * FRAME_BIT_W + LEN_W + ID_W;

  localparam int SHIFT_W = RX_LEN + HDR_LEN;  // one whole packet

  // longest legal run of ones is LEN_W, so this can never hit real packet content
  localparam int LINE_RESET_LEN = 2 * FRAME_BIT_W + LEN_W;

  // tag lfsr
  localparam logic [TAG_W-1:0] TAG_SEED = '1;  // must be non-zero
  localparam logic [TAG_W-1:0] TAG_POLY = 8'hb8;  // taps 7 5 4 3, x^8+x^6+x^5+x^4+1

  typedef enum logic {
    RX_HUNT,  // looking for a valid pair at shift position 0
    RX_SKIP   // bypassing the rest of a detected packet
  } cfg_rx_state_e;

endpackage

`default_nettype wire

/* design/cfg_word_if.sv */
`default_nettype none

interface cfg_word_if;
  import cfg_net_pkg::*;

  logic                     valid;   // one-cycle record strobe
  logic [ID_W-1:0]          id;
  logic [RX_LEN-1:0]        rx;      // raw framed payload
  logic [LEN_W-1:0]         len;     // packet length in bits
  logic [DATA_MAX_BITS-1:0] data;    // compact masked payload
  logic                     credit;  // one pulse per freed downstream slot

  modport src (
    output valid, id, rx, len, data,
    input  credit
  );

  modport dst (
    input  valid, id, rx, len, data,
    output credit
  );

endinterface

`default_nettype wire

/* design/cfg_deframer.sv */
`default_nettype none

module cfg_deframer #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic    clk,
  input  logic    cfg_reset,
  input  logic    cfg_bit_i,   // serial config stream, one bit per clk
  output logic    overflow_o,  // sticky, packet dropped for lack of credit
  cfg_word_if.src out
);
  import cfg_net_pkg::*;

  localparam int CW = $clog2(QUEUE_DEPTH + 1);

  // bit positions in the shift register, oldest bit sits at 0
  localparam int F0_POS  = VALID_W;
  localparam int LEN_LSB = F0_POS + FRAME_BIT_W;
  localparam int F1_POS  = LEN_LSB + LEN_W;
  localparam int ID_LSB  = F1_POS + FRAME_BIT_W;
  localparam int F2_POS  = ID_LSB + ID_W;
  localparam int RX_LSB  = HDR_LEN;

  logic [SHIFT_W-1:0] shift_r;
  logic [LEN_W-1:0]   pkt_len;
  logic [LEN_W-1:0]   count_r;   // bypass counter
  logic [CW-1:0]      credit_r;  // free slots downstream
  cfg_rx_state_e      state_r;
  logic               line_reset;
  logic               detect;
  logic               send;

  assign pkt_len    = shift_r[LEN_LSB +: LEN_W];
  assign line_reset = &shift_r[LINE_RESET_LEN-1:0];  // in-band reset, run of ones

  // valid pair "0 then 1" with all frame bits low
  assign detect = (state_r == RX_HUNT) && (shift_r[VALID_W-1:0] == 2'b10) &&
                  !shift_r[F0_POS] && !shift_r[F1_POS] && !shift_r[F2_POS];
  assign send   = detect && (credit_r != '0);

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      shift_r    <= '0;
      state_r    <= RX_HUNT;
      count_r    <= '0;
      overflow_o <= 1'b0;
      credit_r   <= CW'(QUEUE_DEPTH);
      out.valid  <= 1'b0;
    end else begin
      shift_r   <= {cfg_bit_i, shift_r[SHIFT_W-1:1]};  // new bits enter at the top
      out.valid <= send;

      if (line_reset) begin
        state_r    <= RX_HUNT;
        count_r    <= '0;
        overflow_o <= 1'b0;
      end else if (detect) begin
        if (pkt_len > LEN_W'(1)) begin  // skip the next len-1 bit times
          count_r <= pkt_len - LEN_W'(1);
          state_r <= RX_SKIP;
        end
        if (!send) begin
          overflow_o <= 1'b1;  // queue full, packet is lost
        end
      end else if (state_r == RX_SKIP) begin
        count_r <= count_r - LEN_W'(1);
        if (count_r == LEN_W'(1)) begin
          state_r <= RX_HUNT;
        end
      end

      // credit counter, returned pulse and send may coincide
      case ({out.credit, send})
        2'b10:   credit_r <= credit_r + CW'(1);
        2'b01:   credit_r <= credit_r - CW'(1);
        default: credit_r <= credit_r;
      endcase
    end
  end

  // record payload, captured only on send
  always_ff @(posedge clk) begin
    if (send) begin
      out.id  <= shift_r[ID_LSB +: ID_W];
      out.len <= pkt_len;
      out.rx  <= shift_r[RX_LSB +: RX_LEN];
    end
  end

  assign out.data = '0;  // payload still framed at this stage

endmodule

`default_nettype wire

/* design/cfg_unframer.sv */
`default_nettype none

module cfg_unframer (
  input  logic    clk,
  input  logic    cfg_reset,
  cfg_word_if.dst in,   // framed record from the deframer
  cfg_word_if.src out   // compact record to the queue
);
  import cfg_net_pkg::*;

  localparam int SLOT = FRAME_LEN + FRAME_BIT_W;  // payload bits plus one framing zero

  logic [DATA_MAX_BITS-1:0] payload;      // rx with framing positions removed
  logic [DATA_MAX_BITS-1:0] mask;
  logic [LEN_W-1:0]         framed_bits;  // rx bits before the closing zero
  logic [LEN_W-1:0]         data_bits;    // payload bit count

  // every SLOT-th position is a framing zero, top bit of rx always closes the field
  for (genvar i = 0; i < RX_LEN - FRAME_BIT_W; i++) begin : g_strip
    if ((i + 1) % SLOT != 0) begin : g_keep
      assign payload[i - i / SLOT] = in.rx[i];
    end
  end

  always_comb begin
    framed_bits = in.len - LEN_W'(HDR_LEN + 1);
    data_bits   = framed_bits - framed_bits / LEN_W'(SLOT);
    // too short a packet or too long a payload carries nothing
    if (in.len <= LEN_W'(HDR_LEN + 1) || data_bits > LEN_W'(DATA_MAX_BITS)) begin
      data_bits = '0;
    end
  end

  always_comb begin
    for (int i = 0; i < DATA_MAX_BITS; i++) begin
      mask[i] = (LEN_W'(i) < data_bits);  // keep only the declared bits
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= in.valid;  // one stage of latency, no buffering
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      out.id   <= in.id;
      out.data <= payload & mask;
    end
  end

  assign in.credit = out.credit;  // queue credits go straight back to the deframer
  assign out.rx    = '0;          // framed form not needed past here
  assign out.len   = '0;

endmodule

`default_nettype wire

/* design/cfg_snoop_queue.sv */
`default_nettype none

module cfg_snoop_queue #(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                                   clk,
  input  logic                                   cfg_reset,
  cfg_word_if.dst                                in,
  input  logic                                   credit_i,       // one pulse per consumer credit
  output logic                                   snoop_valid_o,
  output logic [cfg_net_pkg::DATA_MAX_BITS-1:0]  snoop_id_o,     // zeros, tag, id
  output logic [cfg_net_pkg::DATA_MAX_BITS-1:0]  snoop_data_o
);
  import cfg_net_pkg::*;

  localparam int AW    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int NW    = $clog2(QUEUE_DEPTH + 1);
  localparam int OW    = $clog2(OUT_CREDITS + 1);
  localparam int PAD_W = DATA_MAX_BITS - TAG_W - ID_W;

  logic [ID_W-1:0]          id_mem   [QUEUE_DEPTH];
  logic [TAG_W-1:0]         tag_mem  [QUEUE_DEPTH];
  logic [DATA_MAX_BITS-1:0] data_mem [QUEUE_DEPTH];

  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [NW-1:0]    fill_r;      // records held
  logic [OW-1:0]    out_cred_r;  // consumer credits on hand
  logic [TAG_W-1:0] tag_r;
  logic [TAG_W-1:0] tag_next;
  logic             push;
  logic             pop;

  // circular pointer, depth need not be a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(QUEUE_DEPTH - 1)) ? '0 : p + AW'(1);
  endfunction

  assign tag_next = {tag_r[TAG_W-2:0], ^(tag_r & TAG_POLY)};  // shift left, xor of taps in
  assign push     = in.valid;  // never full, deframer holds matching credits
  assign pop      = (out_cred_r != '0) && (fill_r != '0);

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill_r        <= '0;
      out_cred_r    <= OW'(OUT_CREDITS);
      tag_r         <= TAG_SEED;
      snoop_valid_o <= 1'b0;
      in.credit     <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
        tag_r  <= tag_next;  // first record gets the stepped seed
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end

      case ({push, pop})
        2'b10:   fill_r <= fill_r + NW'(1);
        2'b01:   fill_r <= fill_r - NW'(1);
        default: fill_r <= fill_r;
      endcase

      case ({credit_i, pop})
        2'b10:   out_cred_r <= out_cred_r + OW'(1);
        2'b01:   out_cred_r <= out_cred_r - OW'(1);
        default: out_cred_r <= out_cred_r;
      endcase

      snoop_valid_o <= pop;  // single-cycle strobe per record
      in.credit     <= pop;  // slot freed, tell the deframer
    end
  end

  // storage and output payload
  always_ff @(posedge clk) begin
    if (push) begin
      id_mem[wr_ptr]   <= in.id;
      tag_mem[wr_ptr]  <= tag_next;
      data_mem[wr_ptr] <= in.data;
    end
    if (pop) begin
      snoop_id_o   <= {{PAD_W{1'b0}}, tag_mem[rd_ptr], id_mem[rd_ptr]};
      snoop_data_o <= data_mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* design/cfg_snooper_top.sv */
`default_nettype none

module cfg_snooper_top #(
  parameter int QUEUE_DEPTH = 4,  // records the snoop queue can hold
  parameter int OUT_CREDITS = 2   // consumer credits granted at reset
) (
  input  logic                                  clk,
  input  logic                                  cfg_reset,
  input  logic                                  cfg_bit_i,
  input  logic                                  credit_i,
  output logic                                  snoop_valid_o,
  output logic [cfg_net_pkg::DATA_MAX_BITS-1:0] snoop_id_o,
  output logic [cfg_net_pkg::DATA_MAX_BITS-1:0] snoop_data_o,
  output logic                                  overflow_o
);

  cfg_word_if deframed_if ();  // framed record, deframer to unframer
  cfg_word_if unframed_if ();  // masked record, unframer to queue

  cfg_deframer #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) cfg_deframer_inst (
    .clk        (clk),
    .cfg_reset  (cfg_reset),
    .cfg_bit_i  (cfg_bit_i),
    .overflow_o (overflow_o),
    .out        (deframed_if.src)
  );

  cfg_unframer cfg_unframer_inst (
    .clk       (clk),
    .cfg_reset (cfg_reset),
    .in        (deframed_if.dst),
    .out       (unframed_if.src)
  );

  cfg_snoop_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) cfg_snoop_queue_inst (
    .clk           (clk),
    .cfg_reset     (cfg_reset),
    .in            (unframed_if.dst),
    .credit_i      (credit_i),
    .snoop_valid_o (snoop_valid_o),
    .snoop_id_o    (snoop_id_o),
    .snoop_data_o  (snoop_data_o)
  );

endmodule

`default_nettype wire

/* verif/cfg_packet_util.svh */
// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// n fresh bits, one lfsr step per bit taken
function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    s = lfsr_next(s);
    v = {v[30:0], s[0]};
  end
  return v;
endfunction

function automatic int packet_len(input int nbits);
  return HDR_LEN + nbits + nbits / FRAME_LEN + 1;  // header, payload, framing zeros, closer
endfunction

// bit i of the result is the i-th bit on the line
function automatic logic [63:0] build_packet(input logic [7:0] id, input logic [31:0] payload,
                                             input int nbits);
  logic [63:0] p;
  logic [7:0]  len_v;
  int          pos;
  len_v = 8'(packet_len(nbits));
  p     = 64'h2;  // valid pair, 0 then 1, frame zeros stay low
  p     = p | (64'(len_v) << 3) | (64'(id) << 12);  // length lsb first, then id
  pos   = HDR_LEN;
  for (int i = 0; i < nbits; i++) begin
    p   = p | (64'((payload >> i) & 32'd1) << pos);
    pos = ((i + 1) % FRAME_LEN == 0) ? pos + 2 : pos + 1;  // leave a framing zero
  end
  return p;  // closing zero is already low
endfunction

// expected {id word, data} of one accepted packet, steps the model tag
function automatic logic [63:0] expect_record(inout logic [7:0] tag, input logic [7:0] id,
                                              input logic [31:0] payload, input int len);
  int          framed;
  int          nbits;
  logic [31:0] mask;
  framed = len - HDR_LEN - 1;
  nbits  = framed - framed / (FRAME_LEN + 1);  // payload bit count from the length field
  if (framed <= 0 || nbits > DATA_MAX_BITS) begin
    nbits = 0;
  end
  mask = (nbits >= 32) ? '1 : (32'd1 << nbits) - 32'd1;
  tag  = {tag[6:0], tag[7] ^ tag[5] ^ tag[4] ^ tag[3]};  // x^8+x^6+x^5+x^4+1
  return {16'h0000, tag, id, payload & mask};
endfunction

/* verif/cfg_snooper_tb.sv */
`default_nettype none

module cfg_snooper_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cfg_net_pkg::*;

  localparam int QUEUE_DEPTH    = 4;
  localparam int OUT_CREDITS    = 2;
  localparam int PKT_CYCLES     = 120;  // longest packet plus pipeline and credit return
  localparam int NUM_PKTS       = 55;   // packets sent over all tests
  localparam int TIMEOUT_CYCLES = NUM_PKTS * PKT_CYCLES * 2;

  logic                     clk;
  logic                     cfg_reset;
  logic                     cfg_bit_i;
  logic                     credit_i;
  logic                     snoop_valid_o;
  logic [DATA_MAX_BITS-1:0] snoop_id_o;
  logic [DATA_MAX_BITS-1:0] snoop_data_o;
  logic                     overflow_o;

  logic [63:0] exp_q[$];                 // {id word, data} in send order
  logic [15:0] stim_lfsr   = 16'd48362;
  logic [15:0] cons_lfsr   = 16'd48362;  // consumer delays
  logic [7:0]  model_tag;
  bit          hold_credit = 1'b0;       // consumer sits on its credits
  int          recv_cnt    = 0;          // records seen
  int          returned    = 0;          // credits given back
  int          err_cnt     = 0;
  int          cmp_err     = 0;
  int          check_cnt   = 0;
  int          cmp_checks  = 0;
  int          test_cnt    = 0;
  int          test_err    = 0;          // error total when the current test began

  `include "cfg_packet_util.svh"

  cfg_snooper_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) cfg_snooper_top_inst (
    .clk           (clk),
    .cfg_reset     (cfg_reset),
    .cfg_bit_i     (cfg_bit_i),
    .credit_i      (credit_i),
    .snoop_valid_o (snoop_valid_o),
    .snoop_id_o    (snoop_id_o),
    .snoop_data_o  (snoop_data_o),
    .overflow_o    (overflow_o)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // serialize one packet, one bit per clk, line returns to idle 0
  task automatic send_packet(input logic [7:0] id, input logic [31:0] payload,
                             input int nbits, input bit accepted);
    logic [63:0] bits;
    int          len;
    len  = packet_len(nbits);
    bits = build_packet(id, payload, nbits);
    if (accepted) begin
      exp_q.push_back(expect_record(model_tag, id, payload, len));
    end
    for (int i = 0; i < len; i++) begin
      cfg_bit_i <= bits[0];
      bits = bits >> 1;
      @(posedge clk);
    end
    cfg_bit_i <= 1'b0;
  endtask

  task automatic send_random(input int nbits, input bit accepted);
    logic [7:0]  id;
    logic [31:0] payload;
    id      = 8'(take_bits(stim_lfsr, 8));
    payload = take_bits(stim_lfsr, 32);
    send_packet(id, payload, nbits, accepted);
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    check_cnt++;
    if (got !== want) begin
      $display("ERR %0t %s expected %0b got %0b", $time, name, want, got);
      err_cnt++;
    end
  endtask

  // wait for every expected record and every owed credit
  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || recv_cnt != returned) && n < 8 * PKT_CYCLES) begin
      @(posedge clk);
      n++;
    end
    repeat (4) @(posedge clk);  // last credit lands in the queue counter
    if (exp_q.size() != 0 || recv_cnt != returned) begin
      $display("time %0t: %0d expected records never arrived", $time, exp_q.size());
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt + cmp_err == test_err) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt + cmp_err - test_err);
    end
    test_err = err_cnt + cmp_err;
  endtask

  initial begin : stimulus
    int base;
    cfg_reset <= 1'b1;
    cfg_bit_i <= 1'b0;
    model_tag = TAG_SEED;
    repeat (2) @(posedge clk);
    cfg_reset <= 1'b0;
    @(posedge clk);

    for (int k = 0; k < 6; k++) begin
      send_random(DATA_MAX_BITS, 1'b1);
    end
    wait_drain();
    end_test("full width packets, tag order");

    for (int n = 1; n < DATA_MAX_BITS; n++) begin
      send_random(n, 1'b1);  // back to back, next header trails each short payload
    end
    wait_drain();
    end_test("payload lengths 1 to 31");

    send_packet(8'h5a, 32'h0000_0002, DATA_MAX_BITS, 1'b1);  // valid pair hidden in payload
    send_packet(8'hc3, 32'h0002_0002, DATA_MAX_BITS, 1'b1);
    wait_drain();
    end_test("bypass over payload");

    hold_credit = 1'b1;
    base        = recv_cnt;
    for (int k = 0; k < 5; k++) begin
      send_random(DATA_MAX_BITS, 1'b1);
    end
    repeat (SHIFT_W + 20) @(posedge clk);
    check_cnt++;
    if (recv_cnt - base > OUT_CREDITS) begin
      $display("time %0t: %0d records delivered on %0d credits", $time, recv_cnt - base,
               OUT_CREDITS);
      err_cnt++;
    end
    hold_credit = 1'b0;
    wait_drain();
    end_test("consumer withholds credit");

    hold_credit = 1'b1;
    for (int k = 0; k < 8; k++) begin
      send_random(DATA_MAX_BITS, k < OUT_CREDITS + QUEUE_DEPTH);  // past capacity is lost
    end
    repeat (SHIFT_W + 20) @(posedge clk);
    check_bit("overflow_o", overflow_o, 1'b1);
    end_test("overflow without credit");

    for (int k = 0; k < LINE_RESET_LEN; k++) begin
      cfg_bit_i <= 1'b1;
      @(posedge clk);
    end
    cfg_bit_i <= 1'b0;
    repeat (SHIFT_W + 4) @(posedge clk);  // ones reach the bottom of the shift register
    check_bit("overflow_o", overflow_o, 1'b0);
    hold_credit = 1'b0;
    for (int k = 0; k < 3; k++) begin
      send_random(DATA_MAX_BITS, 1'b1);
    end
    wait_drain();
    end_test("in-band line reset");

    $display("tests %0d  records %0d  checks %0d  errors %0d", test_cnt, recv_cnt,
             check_cnt + cmp_checks, err_cnt + cmp_err);
    if (err_cnt + cmp_err == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // pops the model queue on every record
  initial begin : compare
    logic [63:0] want;
    forever begin
      @(posedge clk);
      if (snoop_valid_o) begin
        recv_cnt++;
        if (exp_q.size() == 0) begin
          $display("time %0t: record %h arrived with none expected", $time, snoop_id_o);
          cmp_err++;
        end else begin
          want       = exp_q.pop_front();
          cmp_checks = cmp_checks + 2;
          if (snoop_id_o !== want[63:32]) begin
            $display("ERR %0t snoop_id_o expected %h got %h", $time, want[63:32], snoop_id_o);
            cmp_err++;
          end
          if (snoop_data_o !== want[31:0]) begin
            $display("ERR %0t snoop_data_o expected %h got %h", $time, want[31:0],
                     snoop_data_o);
            cmp_err++;
          end
        end
      end
    end
  end

  // hands back one credit per record after 0 to 7 cycles
  initial begin : consumer
    int delay;
    credit_i <= 1'b0;
    forever begin
      @(posedge clk);
      if (recv_cnt != returned && !hold_credit) begin
        delay = int'(take_bits(cons_lfsr, 3));
        repeat (delay) @(posedge clk);
        credit_i <= 1'b1;
        @(posedge clk);
        credit_i <= 1'b0;
        returned++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* config_net.f */
+incdir+verif
design/cfg_net_pkg.sv
design/cfg_word_if.sv
design/cfg_deframer.sv
design/cfg_unframer.sv
design/cfg_snoop_queue.sv
design/cfg_snooper_top.sv
verif/cfg_snooper_tb.sv

/* run.sh */
#!/bin/sh
# build and run the snooper testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f config_net.f --top-module cfg_snooper_tb -o cfg_snooper_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/cfg_snooper_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
